// File: logic/otter_pkg.sv
package otter_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [6:0]  opcode_t;

    // Opcodes handled by the core
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;

    // Load and store sizes
    localparam logic [2:0] FUNCT3_LB  = 3'b000;
    localparam logic [2:0] FUNCT3_LH  = 3'b001;
    localparam logic [2:0] FUNCT3_LW  = 3'b010;
    localparam logic [2:0] FUNCT3_LBU = 3'b100;
    localparam logic [2:0] FUNCT3_LHU = 3'b101;
    localparam logic [2:0] FUNCT3_SB  = 3'b000;
    localparam logic [2:0] FUNCT3_SH  = 3'b001;
    localparam logic [2:0] FUNCT3_SW  = 3'b010;

    // Branch conditions
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    //////////////////////////////////////////////////
    // Control selectors
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_sel_e;
    typedef enum logic       {SRC_B_RS2, SRC_B_IMM} src_b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC_INC} wb_sel_e;
    typedef enum logic [2:0] {PC_INC, PC_BRANCH, PC_JAL, PC_JALR, PC_RESET} pc_sel_e;
    typedef enum logic [1:0] {ST_INIT, ST_EXEC, ST_WR_BK} cu_state_e;

    // Everything the decoder steers in one bundle
    typedef struct packed {
        alu_op_e    alu_op;
        src_a_sel_e src_a_sel;
        src_b_sel_e src_b_sel;
        wb_sel_e    wb_sel;
        pc_sel_e    pc_sel;
        logic       is_branch;
        logic       pc_w_en;
        logic       rf_w_en;
        logic       dmem_r_en;
        logic       dmem_w_en;
        logic       stall;
    } ctrl_t;

endpackage

// File: logic/otter_decoder.sv
`timescale 1ns/10ps

module otter_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  otter_pkg::word_t instrn,
    input  logic             taken,
    output otter_pkg::ctrl_t ctrl
);
    import otter_pkg::*;

    cu_state_e  state;
    cu_state_e  next_state;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = instrn[6:0];
    assign funct3 = instrn[14:12];
    // Selects SUB and SRA
    assign alt    = instrn[30];

    // funct3 to ALU operation; SUB only exists for register form
    function automatic alu_op_e alu_func(input logic [2:0] f3, input logic alt_bit,
                                         input logic is_reg);
        case (f3)
            3'b000:  return (alt_bit && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_INIT;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////

    always_comb begin
        // Idle defaults, nothing written
        ctrl           = '0;
        ctrl.alu_op    = ALU_ADD;
        ctrl.src_a_sel = SRC_A_RS1;
        ctrl.src_b_sel = SRC_B_RS2;
        ctrl.wb_sel    = WB_ALU;
        ctrl.pc_sel    = PC_INC;
        next_state     = state;
        case (state)
            ST_INIT: begin
                // Load the reset vector into the PC
                ctrl.pc_sel  = PC_RESET;
                ctrl.pc_w_en = 1'b1;
                next_state   = ST_EXEC;
            end
            ST_EXEC: begin
                ctrl.pc_w_en = 1'b1;
                case (opcode)
                    OPCODE_OP: begin
                        ctrl.alu_op  = alu_func(funct3, alt, 1'b1);
                        ctrl.rf_w_en = 1'b1;
                    end
                    OPCODE_OP_IMM: begin
                        ctrl.alu_op    = alu_func(funct3, alt, 1'b0);
                        ctrl.src_b_sel = SRC_B_IMM;
                        ctrl.rf_w_en   = 1'b1;
                    end
                    OPCODE_LUI: begin
                        ctrl.alu_op    = ALU_COPY_B;
                        ctrl.src_a_sel = SRC_A_ZERO;
                        ctrl.src_b_sel = SRC_B_IMM;
                        ctrl.rf_w_en   = 1'b1;
                    end
                    OPCODE_AUIPC: begin
                        ctrl.src_a_sel = SRC_A_PC;
                        ctrl.src_b_sel = SRC_B_IMM;
                        ctrl.rf_w_en   = 1'b1;
                    end
                    OPCODE_JAL, OPCODE_JALR: begin
                        // Link value is PC+4
                        ctrl.wb_sel  = WB_PC_INC;
                        ctrl.pc_sel  = (opcode == OPCODE_JAL) ? PC_JAL : PC_JALR;
                        ctrl.rf_w_en = 1'b1;
                    end
                    OPCODE_BRANCH: begin
                        // Condition resolved in the next-PC logic
                        ctrl.is_branch = 1'b1;
                        ctrl.pc_sel    = PC_BRANCH;
                    end
                    OPCODE_STORE: begin
                        ctrl.src_b_sel = SRC_B_IMM;
                        ctrl.dmem_w_en = 1'b1;
                    end
                    OPCODE_LOAD: begin
                        // Hold PC and instruction while memory answers
                        ctrl.src_b_sel = SRC_B_IMM;
                        ctrl.dmem_r_en = 1'b1;
                        ctrl.stall     = 1'b1;
                        ctrl.pc_w_en   = 1'b0;
                        next_state     = ST_WR_BK;
                    end
                    // Anything else just steps over
                    default: ;
                endcase
            end
            ST_WR_BK: begin
                // Read data is on the bus now
                ctrl.src_b_sel = SRC_B_IMM;
                ctrl.wb_sel    = WB_LOAD;
                ctrl.rf_w_en   = 1'b1;
                ctrl.pc_w_en   = 1'b1;
                next_state     = ST_EXEC;
            end
            default: next_state = ST_INIT;
        endcase
    end

endmodule

// File: logic/otter_regfile.sv
`timescale 1ns/10ps

module otter_regfile (
    input  logic                 clk,
    input  otter_pkg::reg_addr_t rs1_addr,
    input  otter_pkg::reg_addr_t rs2_addr,
    input  otter_pkg::reg_addr_t rd_addr,
    input  logic                 w_en,
    input  otter_pkg::word_t     w_data,
    output otter_pkg::word_t     rs1,
    output otter_pkg::word_t     rs2
);
    import otter_pkg::*;

    word_t regs [0:31];

    // Single write port, x0 never stored
    always_ff @(posedge clk) begin
        if (w_en && rd_addr != '0) begin
            regs[rd_addr] <= w_data;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1 = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2 = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: logic/otter_imm_gen.sv
`timescale 1ns/10ps

module otter_imm_gen (
    input  otter_pkg::word_t instrn,
    output otter_pkg::word_t imm_i,
    output otter_pkg::word_t imm_s,
    output otter_pkg::word_t imm_b,
    output otter_pkg::word_t imm_u,
    output otter_pkg::word_t imm_j
);
    import otter_pkg::*;

    logic sign;

    // Bit 31 is the sign in every format
    assign sign = instrn[31];

    assign imm_i = {{21{sign}}, instrn[30:20]};
    assign imm_s = {{21{sign}}, instrn[30:25], instrn[11:7]};
    // Branch and jump offsets are in halfwords
    assign imm_b = {{20{sign}}, instrn[7], instrn[30:25], instrn[11:8], 1'b0};
    assign imm_j = {{12{sign}}, instrn[19:12], instrn[20], instrn[30:21], 1'b0};
    // Upper immediate fills the top 20 bits
    assign imm_u = {instrn[31:12], 12'd0};

endmodule

// File: logic/otter_alu.sv
`timescale 1ns/10ps

module otter_alu (
    input  otter_pkg::word_t   src_a,
    input  otter_pkg::word_t   src_b,
    input  otter_pkg::alu_op_e op,
    output otter_pkg::word_t   result
);
    import otter_pkg::*;

    logic [4:0] shamt;

    // Only the low five bits shift
    assign shamt = src_b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = src_a + src_b;
            ALU_SUB:    result = src_a - src_b;
            ALU_SLL:    result = src_a << shamt;
            ALU_SLT:    result = {31'd0, $signed(src_a) < $signed(src_b)};
            ALU_SLTU:   result = {31'd0, src_a < src_b};
            ALU_XOR:    result = src_a ^ src_b;
            ALU_SRL:    result = src_a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:    result = word_t'($signed(src_a) >>> shamt);
            ALU_OR:     result = src_a | src_b;
            ALU_AND:    result = src_a & src_b;
            // LUI path
            ALU_COPY_B: result = src_b;
            default:    result = src_a + src_b;
        endcase
    end

endmodule

// File: logic/otter_next_pc.sv
`timescale 1ns/10ps

module otter_next_pc #(
    parameter otter_pkg::word_t reset_vec = 32'h0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  otter_pkg::ctrl_t ctrl,
    input  logic [2:0]       funct3,
    input  otter_pkg::word_t rs1,
    input  otter_pkg::word_t rs2,
    input  otter_pkg::word_t imm_i,
    input  otter_pkg::word_t imm_b,
    input  otter_pkg::word_t imm_j,
    output otter_pkg::word_t pc,
    output otter_pkg::word_t pc_inc,
    output otter_pkg::word_t next_pc,
    output logic             taken
);
    import otter_pkg::*;

    word_t br_target;
    word_t jal_target;
    word_t jalr_target;

    assign pc_inc      = pc + 32'd4;
    assign br_target   = pc + imm_b;
    assign jal_target  = pc + imm_j;
    // JALR drops bit 0 of the sum
    assign jalr_target = (rs1 + imm_i) & ~32'd1;

    // Branch condition from rs1 and rs2
    always_comb begin
        case (funct3)
            FUNCT3_BEQ:  taken = (rs1 == rs2);
            FUNCT3_BNE:  taken = (rs1 != rs2);
            FUNCT3_BLT:  taken = ($signed(rs1) < $signed(rs2));
            FUNCT3_BGE:  taken = ($signed(rs1) >= $signed(rs2));
            FUNCT3_BLTU: taken = (rs1 < rs2);
            FUNCT3_BGEU: taken = (rs1 >= rs2);
            default:     taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.pc_sel)
            // Target only when the condition holds
            PC_BRANCH: next_pc = (ctrl.is_branch && taken) ? br_target : pc_inc;
            PC_JAL:    next_pc = jal_target;
            PC_JALR:   next_pc = jalr_target;
            PC_RESET:  next_pc = reset_vec;
            default:   next_pc = pc_inc;
        endcase
    end

    // PC register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_vec;
        end else if (ctrl.pc_w_en) begin
            pc <= next_pc;
        end
    end

endmodule

// File: logic/otter_lsu.sv
`timescale 1ns/10ps

module otter_lsu (
    input  otter_pkg::ctrl_t ctrl,
    input  logic [2:0]       funct3,
    input  logic [1:0]       offset,
    input  otter_pkg::word_t rs2,
    input  otter_pkg::word_t dmem_r_data,
    output otter_pkg::word_t w_data,
    output otter_pkg::strb_t w_strb,
    output otter_pkg::word_t load_data
);
    import otter_pkg::*;

    logic [4:0] byte_shift;
    strb_t      base_strb;
    word_t      r_shifted;

    // Byte offset in bits
    assign byte_shift = {offset, 3'b000};

    //////////////////////////////////////////////////
    // Store side
    //////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            FUNCT3_SB: base_strb = 4'b0001;
            FUNCT3_SH: base_strb = 4'b0011;
            default:   base_strb = 4'b1111;
        endcase
    end

    // Move data and lanes up to the addressed byte
    assign w_data = rs2 << byte_shift;
    assign w_strb = ctrl.dmem_w_en ? strb_t'(base_strb << offset) : '0;

    //////////////////////////////////////////////////
    // Load side
    //////////////////////////////////////////////////

    assign r_shifted = dmem_r_data >> byte_shift;

    always_comb begin
        case (funct3)
            FUNCT3_LB:  load_data = {{24{r_shifted[7]}}, r_shifted[7:0]};
            FUNCT3_LH:  load_data = {{16{r_shifted[15]}}, r_shifted[15:0]};
            FUNCT3_LBU: load_data = {24'd0, r_shifted[7:0]};
            FUNCT3_LHU: load_data = {16'd0, r_shifted[15:0]};
            // LW and anything else
            default:    load_data = r_shifted;
        endcase
    end

endmodule

// File: logic/otter_mcu.sv
`timescale 1ns/10ps

module otter_mcu #(
    parameter otter_pkg::word_t reset_vec = 32'h0
) (
    input  logic             clk,
    input  logic             rst_n,
    output otter_pkg::word_t imem_addr,
    input  otter_pkg::word_t imem_r_data,
    output otter_pkg::word_t dmem_addr,
    output logic             dmem_r_en,
    output logic             dmem_w_en,
    output otter_pkg::strb_t dmem_w_strb,
    output otter_pkg::word_t dmem_w_data,
    input  otter_pkg::word_t dmem_r_data
);
    import otter_pkg::*;

    ctrl_t      ctrl;
    word_t      instrn, prev_instrn;
    logic       prev_stall;
    logic [1:0] offset_q, lsu_offset;
    logic       taken;
    word_t      rs1, rs2, rf_w_data;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      imm_sel, alu_a, alu_b, alu_result;
    word_t      pc, pc_inc, next_pc, load_data;

    //////////////////////////////////////////////////
    // Instruction hold across a load
    //////////////////////////////////////////////////

    // Replay the word while the fetch address was held
    assign instrn    = prev_stall ? prev_instrn : imem_r_data;
    assign imem_addr = ctrl.stall ? pc : next_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_stall <= 1'b0;
        end else begin
            prev_stall <= ctrl.stall;
        end
    end

    // Load byte offset kept for writeback
    always_ff @(posedge clk) begin
        prev_instrn <= instrn;
        offset_q    <= alu_result[1:0];
    end

    otter_decoder u_decoder (
        .clk(clk), .rst_n(rst_n), .instrn(instrn), .taken(taken), .ctrl(ctrl)
    );

    otter_regfile u_regfile (
        .clk(clk), .rs1_addr(instrn[19:15]), .rs2_addr(instrn[24:20]),
        .rd_addr(instrn[11:7]), .w_en(ctrl.rf_w_en), .w_data(rf_w_data),
        .rs1(rs1), .rs2(rs2)
    );

    otter_imm_gen u_imm_gen (
        .instrn(instrn), .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b),
        .imm_u(imm_u), .imm_j(imm_j)
    );

    //////////////////////////////////////////////////
    // Operand and writeback muxes
    //////////////////////////////////////////////////

    always_comb begin
        case (instrn[6:0])
            OPCODE_STORE:              imm_sel = imm_s;
            OPCODE_LUI, OPCODE_AUIPC:  imm_sel = imm_u;
            default:                   imm_sel = imm_i;
        endcase
        case (ctrl.src_a_sel)
            SRC_A_PC:   alu_a = pc;
            SRC_A_ZERO: alu_a = '0;
            default:    alu_a = rs1;
        endcase
        alu_b = (ctrl.src_b_sel == SRC_B_IMM) ? imm_sel : rs2;
        case (ctrl.wb_sel)
            WB_LOAD:   rf_w_data = load_data;
            WB_PC_INC: rf_w_data = pc_inc;
            default:   rf_w_data = alu_result;
        endcase
    end

    otter_alu u_alu (.src_a(alu_a), .src_b(alu_b), .op(ctrl.alu_op), .result(alu_result));

    otter_next_pc #(.reset_vec(reset_vec)) u_next_pc (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .funct3(instrn[14:12]),
        .rs1(rs1), .rs2(rs2), .imm_i(imm_i), .imm_b(imm_b), .imm_j(imm_j),
        .pc(pc), .pc_inc(pc_inc), .next_pc(next_pc), .taken(taken)
    );

    // Writeback uses the registered offset
    assign lsu_offset = prev_stall ? offset_q : alu_result[1:0];

    otter_lsu u_lsu (
        .ctrl(ctrl), .funct3(instrn[14:12]), .offset(lsu_offset), .rs2(rs2),
        .dmem_r_data(dmem_r_data), .w_data(dmem_w_data), .w_strb(dmem_w_strb),
        .load_data(load_data)
    );

    // Bus sees word addresses only
    assign dmem_addr = {alu_result[31:2], 2'b00};
    assign dmem_r_en = ctrl.dmem_r_en;
    assign dmem_w_en = ctrl.dmem_w_en;

endmodule

// File: include/rv_encode.svh
`ifndef RV_ENCODE_SVH
`define RV_ENCODE_SVH

//////////////////////////////////////////////////
// RV32I instruction assembly from fields
//////////////////////////////////////////////////

// Register form, opcode OP
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// Immediate form, used by OP_IMM, LOAD and JALR
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

// Store, immediate split around rs2 and rs1
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

// Branch offset in bytes, bit 0 dropped
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

// LUI and AUIPC
function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

// JAL with a 21-bit byte offset
function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

`endif

// File: sim/tb_otter.sv
`timescale 1ns/10ps

module tb_otter;
    import otter_pkg::*;

    `include "rv_encode.svh"

    // One expected store on the data bus
    typedef struct packed {
        word_t addr;
        strb_t strb;
        word_t data;
    } store_exp_t;

    localparam int MEM_WORDS = 256;
    // Byte address where results are stored
    localparam int RES_ADDR  = 'h200;

    logic       clk;
    logic       rst_n;
    word_t      imem_addr;
    word_t      imem_r_data = '0;
    word_t      dmem_addr;
    logic       dmem_r_en;
    logic       dmem_w_en;
    strb_t      dmem_w_strb;
    word_t      dmem_w_data;
    word_t      dmem_r_data = '0;

    word_t      imem [MEM_WORDS];
    word_t      dmem [MEM_WORDS];
    logic [7:0] ia_q = '0;
    logic [7:0] da_q = '0;

    store_exp_t exp_q [$];
    store_exp_t cur;
    word_t      lane_msk;
    int         pc_w;
    int         prog_len;
    int         errs;
    int         checks;
    logic       prog_ready = 1'b0;
    word_t      op_a, op_b, ld_word;

    otter_mcu #(.reset_vec(32'h0)) dut (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_r_data(imem_r_data),
        .dmem_addr(dmem_addr), .dmem_r_en(dmem_r_en), .dmem_w_en(dmem_w_en),
        .dmem_w_strb(dmem_w_strb), .dmem_w_data(dmem_w_data),
        .dmem_r_data(dmem_r_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////

    // Address taken at the rising edge, write lands there too
    always @(posedge clk) begin
        ia_q <= imem_addr[9:2];
        // Data address only latched on an enabled read
        if (dmem_r_en) begin
            da_q <= dmem_addr[9:2];
        end
        if (dmem_w_en) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_w_strb[i]) begin
                    dmem[dmem_addr[9:2]][8*i +: 8] = dmem_w_data[8*i +: 8];
                end
            end
        end
    end

    // Read data driven half a cycle later, valid for the whole next cycle
    always @(negedge clk) begin
        imem_r_data <= imem[ia_q];
        dmem_r_data <= dmem[da_q];
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Integer result from funct3 and the bit-30 selector
    function automatic word_t rv_ref(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Bytes picked from the addressed lane, then extended
    function automatic word_t load_ref(input logic [2:0] f3, input word_t w,
                                       input logic [1:0] off);
        word_t s;
        s = w >> (8 * off);
        case (f3)
            3'd0:    return {{24{s[7]}}, s[7:0]};
            3'd1:    return {{16{s[15]}}, s[15:0]};
            3'd4:    return {24'd0, s[7:0]};
            3'd5:    return {16'd0, s[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Size-based lanes before the offset shift
    function automatic strb_t size_strb(input logic [2:0] f3);
        case (f3[1:0])
            2'd0:    return 4'b0001;
            2'd1:    return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic word_t lane_mask(input strb_t s);
        word_t m;
        m = '0;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{s[i]}};
        end
        return m;
    endfunction

    //////////////////////////////////////////////////
    // Program assembly
    //////////////////////////////////////////////////

    task automatic emit(input word_t w);
        imem[pc_w / 4] = w;
        pc_w += 4;
    endtask

    task automatic expect_store(input word_t a, input strb_t s, input word_t d);
        store_exp_t e;
        e.addr = a;
        e.strb = s;
        e.data = d;
        exp_q.push_back(e);
    endtask

    // SW x3 to the result address
    task automatic store_result(input word_t v);
        emit(enc_s(12'(RES_ADDR), 5'd3, 5'd0, 3'b010));
        expect_store(word_t'(RES_ADDR), 4'b1111, v);
    endtask

    // Ten register ops on x1 and x2; SUB and SRA come last
    task automatic alu_section();
        logic [2:0] f3;
        logic       alt;
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            alt = (k >= 8);
            emit(enc_r({1'b0, alt, 5'd0}, 5'd2, 5'd1, f3, 5'd3));
            store_result(rv_ref(f3, alt, op_a, op_b));
        end
    endtask

    task automatic imm_section();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [19:0] u;
        word_t       here;
        for (int k = 0; k < 9; k++) begin
            f3  = (k < 8) ? 3'(k) : 3'd5;
            alt = (k == 8);
            imm = 12'($urandom());
            // Shifts carry shamt and the SRA selector
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, alt, 5'd0, imm[4:0]};
            end
            emit(enc_i(imm, 5'd1, f3, 5'd3, 7'b0010011));
            store_result(rv_ref(f3, alt, op_a, {{20{imm[11]}}, imm}));
        end
        u = 20'($urandom());
        emit(enc_u(u, 5'd3, 7'b0110111));
        store_result({u, 12'd0});
        // AUIPC adds to its own address
        u    = 20'($urandom());
        here = word_t'(pc_w);
        emit(enc_u(u, 5'd3, 7'b0010111));
        store_result(here + {u, 12'd0});
    endtask

    // Every legal offset of the word at byte 8
    task automatic load_section();
        logic [2:0] f3;
        int         step;
        for (int k = 0; k < 6; k++) begin
            f3 = 3'(k);
            if (k != 3) begin
                step = (f3[1:0] == 2'd0) ? 1 : ((f3[1:0] == 2'd1) ? 2 : 4);
                for (int off = 0; off < 4; off += step) begin
                    emit(enc_i(12'(8 + off), 5'd0, f3, 5'd3, 7'b0000011));
                    store_result(load_ref(f3, ld_word, 2'(off)));
                end
            end
        end
    endtask

    task automatic store_section();
        logic [2:0] f3;
        int         step;
        for (int k = 0; k < 3; k++) begin
            f3   = 3'(k);
            step = (k == 0) ? 1 : ((k == 1) ? 2 : 4);
            for (int off = 0; off < 4; off += step) begin
                emit(enc_s(12'(RES_ADDR + off), 5'd1, 5'd0, f3));
                expect_store(word_t'(RES_ADDR), strb_t'(size_strb(f3) << off),
                             op_a << (8 * off));
            end
        end
    endtask

    // x3 is 1 on the taken path and 2 on the fall-through path
    task automatic branch_case(input logic [2:0] f3, input logic [11:0] a, input logic [11:0] b);
        emit(enc_i(a, 5'd0, 3'd0, 5'd6, 7'b0010011));
        emit(enc_i(b, 5'd0, 3'd0, 5'd7, 7'b0010011));
        emit(enc_b(13'd12, 5'd7, 5'd6, f3));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd3, 7'b0010011));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd3, 7'b0010011));
        if (branch_ref(f3, {{20{a[11]}}, a}, {{20{b[11]}}, b})) begin
            store_result(32'd1);
        end else begin
            store_result(32'd2);
        end
    endtask

    task automatic branch_section();
        // Equal, signed greater, signed less
        logic [11:0] pa [3] = '{12'd5, 12'd5, 12'hffd};
        logic [11:0] pb [3] = '{12'd5, 12'hffd, 12'd5};
        for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 3) begin
                for (int p = 0; p < 3; p++) begin
                    branch_case(3'(k), pa[p], pb[p]);
                end
            end
        end
    endtask

    task automatic jump_section();
        word_t here;
        // JAL skips one word, link lands in x3
        here = word_t'(pc_w);
        emit(enc_j(21'd8, 5'd3));
        emit(enc_i(12'd7, 5'd0, 3'd0, 5'd3, 7'b0010011));
        store_result(here + 32'd4);
        // JALR target with bit 0 set, which the core must clear
        here = word_t'(pc_w + 4);
        emit(enc_i(12'((here + 32'd8) | 32'd1), 5'd0, 3'd0, 5'd8, 7'b0010011));
        emit(enc_i(12'd0, 5'd8, 3'd0, 5'd3, 7'b1100111));
        emit(enc_i(12'd7, 5'd0, 3'd0, 5'd3, 7'b0010011));
        store_result(here + 32'd4);
    endtask

    task automatic build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            // Custom-0 opcode steps over as a NOP
            imem[i] = {8'(i), 8'(~i), 9'd0, 7'b0001011};
            dmem[i] = {8'hd0, 8'(i), 8'(i * 3), 8'(~i)};
        end
        op_a    = $urandom();
        op_b    = $urandom();
        ld_word = $urandom();
        dmem[0] = op_a;
        dmem[1] = op_b;
        dmem[2] = ld_word;
        pc_w    = 0;
        emit(enc_i(12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011));
        emit(enc_i(12'd4, 5'd0, 3'b010, 5'd2, 7'b0000011));
        alu_section();
        imm_section();
        load_section();
        store_section();
        branch_section();
        jump_section();
        // Spin in place at the end
        emit(enc_j(21'd0, 5'd0));
        prog_len = pc_w / 4;
    endtask

    //////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////

    // No memory traffic while reset is held
    always @(posedge clk) begin
        if (!rst_n) begin
            checks++;
            assert (!dmem_r_en && !dmem_w_en) else begin
                errs++;
                $display("Memory enable raised during reset at %0t", $time);
            end
        end
    end

    // Each store compared with the next expected one
    always @(posedge clk) begin
        if (rst_n && dmem_w_en) begin
            if (exp_q.size() == 0) begin
                errs++;
                $display("Store at %0t with no store expected", $time);
            end else begin
                cur      = exp_q.pop_front();
                lane_msk = lane_mask(cur.strb);
                checks  += 3;
                assert (dmem_addr == cur.addr) else begin
                    errs++;
                    $display("ERR %0t dmem_addr exp=%h got=%h", $time, cur.addr, dmem_addr);
                end
                assert (dmem_w_strb == cur.strb) else begin
                    errs++;
                    $display("ERR %0t dmem_w_strb exp=%h got=%h", $time, cur.strb, dmem_w_strb);
                end
                assert ((dmem_w_data & lane_msk) == (cur.data & lane_msk)) else begin
                    errs++;
                    $display("ERR %0t dmem_w_data exp=%h got=%h", $time,
                             cur.data & lane_msk, dmem_w_data & lane_msk);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        rst_n  = 1'b0;
        errs   = 0;
        checks = 0;
        void'($urandom(97));
        build_program();
        prog_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // First fetch after release is the reset vector
        @(posedge clk);
        checks++;
        assert (imem_addr == 32'h0) else begin
            errs++;
            $display("ERR %0t imem_addr exp=%h got=%h", $time, 32'h0, imem_addr);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("checks=%0d errors=%0d", checks, errs);
        if (errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Two cycles per instruction at most, plus reset and margin
    initial begin
        wait (prog_ready);
        repeat (prog_len * 2 + 108) @(posedge clk);
        $display("Timeout with %0d stores still outstanding", exp_q.size());
        $display("checks=%0d errors=%0d", checks, errs + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
logic/otter_pkg.sv
logic/otter_decoder.sv
logic/otter_regfile.sv
logic/otter_imm_gen.sv
logic/otter_alu.sv
logic/otter_next_pc.sv
logic/otter_lsu.sv
logic/otter_mcu.sv
sim/tb_otter.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_otter \
    -f sim.f -o tb_otter > sim.log 2>&1 \
    && ./obj_dir/tb_otter >> sim.log 2>&1 \
    || { cat sim.log; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1
